// File: common/rob_pkg.sv
/*
 * Shared sizes, ids and the exception encoding for the reorder buffer.
 * Imported by every RTL block and by the testbench reference model.
 */

package rob_pkg;

  // --------------------------------------------------------------------
  // sizing
  // --------------------------------------------------------------------
  localparam int DISP_SIZE      = 4;   // slots per dispatch group
  localparam int CMT_ENTRY_SIZE = 8;   // groups held in flight
  localparam int CMT_ENTRY_W    = $clog2(CMT_ENTRY_SIZE);
  localparam int CMT_BUS_SIZE   = 2;   // done report ports

  localparam int VADDR_W    = 32;
  localparam int INST_BYTES = 4;       // pc step between slots

  // --------------------------------------------------------------------
  // ids and masks
  // --------------------------------------------------------------------

  // wrap bit on top, entry index below
  typedef logic [CMT_ENTRY_W:0] cmt_id_t;

  // one bit per slot of a group
  typedef logic [DISP_SIZE-1:0] grp_id_t;

  typedef logic [VADDR_W-1:0] vaddr_t;

  // must hold CMT_ENTRY_SIZE itself
  typedef logic [CMT_ENTRY_W:0] credit_t;

  // --------------------------------------------------------------------
  // exception causes
  // --------------------------------------------------------------------
  // values follow the risc-v mcause numbering
  typedef enum logic [3:0] {
    EXC_NONE        = 4'd0,
    INST_ACC_FAULT  = 4'd1,
    ILLEGAL_INST    = 4'd2,
    LOAD_ACC_FAULT  = 4'd5,
    STORE_ACC_FAULT = 4'd7,
    ECALL           = 4'd8
  } except_t;

endpackage

// File: rtl/oh_select.sv
/*
 * AND-OR multiplexer for a one-hot select, payload given by type parameter T.
 * An all-zero select returns zero.
 */

`timescale 1ns/1ps

module oh_select #(
  parameter type T     = logic,
  parameter int  WORDS = 4
) (
  input  logic [WORDS-1:0] i_oh,
  input  T                 i_data [WORDS],
  output T                 o_selected
);

  logic [$bits(T)-1:0] w_acc;

  always_comb begin
    w_acc = '0;
    for (int w = 0; w < WORDS; w++) begin
      w_acc = w_acc | (i_data[w] & {$bits(T){i_oh[w]}});
    end
  end

  assign o_selected = T'(w_acc);  // back to payload type

endmodule

// File: rob/rob_ptr.sv
/*
 * Dispatch (in) and commit (out) pointers of the reorder buffer.
 * Equal pointers mean empty; same index with differing wrap bits means full.
 */

`timescale 1ns/1ps

module rob_ptr
  import rob_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_in_valid,   // group dispatched this cycle
  input  logic    i_out_valid,  // oldest group retired this cycle
  output cmt_id_t o_in_ptr,
  output cmt_id_t o_out_ptr
);

  // step one entry, toggling the wrap bit past the last index
  function automatic cmt_id_t next_ptr(input cmt_id_t ptr);
    cmt_id_t nxt;
    if (ptr[CMT_ENTRY_W-1:0] == CMT_ENTRY_W'(CMT_ENTRY_SIZE - 1)) begin
      nxt = {~ptr[CMT_ENTRY_W], {CMT_ENTRY_W{1'b0}}};
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_ptr  <= '0;
      o_out_ptr <= '0;
    end else begin
      if (i_in_valid) begin
        o_in_ptr <= next_ptr(o_in_ptr);
      end
      if (i_out_valid) begin
        o_out_ptr <= next_ptr(o_out_ptr);
      end
    end
  end

endmodule

// File: rob/rob_entry.sv
/*
 * One reorder buffer entry: holds a dispatch group and tracks done,
 * exception and dead state per slot until the group commits.
 */

`timescale 1ns/1ps

module rob_entry
  import rob_pkg::*;
#(
  parameter int ENTRY_IDX = 0
) (
  input  logic    i_clk,
  input  logic    i_reset_n,

  input  logic    i_load_valid,
  input  logic    i_in_wrap,
  input  grp_id_t i_disp_grp_id,
  input  vaddr_t  i_disp_pc,
  input  grp_id_t i_disp_except_valid,
  input  except_t i_disp_except_type [DISP_SIZE],

  input  logic    i_done_valid        [CMT_BUS_SIZE],
  input  cmt_id_t i_done_cmt_id       [CMT_BUS_SIZE],
  input  grp_id_t i_done_grp_id       [CMT_BUS_SIZE],
  input  logic    i_done_except_valid [CMT_BUS_SIZE],
  input  except_t i_done_except_type  [CMT_BUS_SIZE],

  input  logic    i_kill,
  input  logic    i_commit_finish,

  output logic    o_valid,
  output grp_id_t o_grp_id,
  output grp_id_t o_done_grp_id,
  output grp_id_t o_except_valid,
  output except_t o_except_type [DISP_SIZE],
  output grp_id_t o_dead,
  output vaddr_t  o_pc,
  output logic    o_all_done
);

  logic    r_valid;
  logic    r_wrap;
  grp_id_t r_grp_id;
  grp_id_t r_done;
  grp_id_t r_except_valid;
  except_t r_except_type [DISP_SIZE];
  grp_id_t r_dead;
  vaddr_t  r_pc;

  cmt_id_t                 w_my_id;
  logic [CMT_BUS_SIZE-1:0] w_done_hit;
  grp_id_t                 w_done_set;
  grp_id_t                 w_exc_set;
  grp_id_t                 w_disp_exc;

  assign w_my_id    = {r_wrap, CMT_ENTRY_W'(ENTRY_IDX)};
  assign w_disp_exc = i_disp_except_valid & i_disp_grp_id;  // done on entry

  // --------------------------------------------------------------------
  // done report decode
  // --------------------------------------------------------------------
  always_comb begin
    w_done_set = '0;
    w_exc_set  = '0;
    for (int p = 0; p < CMT_BUS_SIZE; p++) begin
      w_done_hit[p] = r_valid & i_done_valid[p] & (i_done_cmt_id[p] == w_my_id);
      if (w_done_hit[p]) begin
        w_done_set = w_done_set | i_done_grp_id[p];
        if (i_done_except_valid[p]) begin
          w_exc_set = w_exc_set | i_done_grp_id[p];
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // per-slot state
  // --------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_done         <= '0;
      r_except_valid <= '0;
      r_dead         <= '0;
    end else if (i_load_valid) begin
      r_valid <= 1'b1;
      if (i_kill) begin             // dispatched inside a flush window
        r_done         <= i_disp_grp_id;
        r_except_valid <= '0;
        r_dead         <= i_disp_grp_id;
      end else begin
        r_done         <= w_disp_exc;
        r_except_valid <= w_disp_exc;
        r_dead         <= '0;
      end
    end else if (i_commit_finish) begin
      r_valid        <= 1'b0;
      r_done         <= '0;
      r_except_valid <= '0;
      r_dead         <= '0;
    end else if (r_valid && i_kill) begin
      // younger than a flushing commit, retire as all dead
      r_done         <= r_grp_id;
      r_except_valid <= '0;
      r_dead         <= r_grp_id;
    end else begin
      r_done         <= r_done | w_done_set;
      r_except_valid <= r_except_valid | (w_exc_set & ~r_dead);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_wrap        <= i_in_wrap;
      r_grp_id      <= i_disp_grp_id;
      r_pc          <= i_disp_pc;
      r_except_type <= i_disp_except_type;
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        for (int p = 0; p < CMT_BUS_SIZE; p++) begin
          if (w_done_hit[p] && i_done_except_valid[p] && i_done_grp_id[p][d]) begin
            r_except_type[d] <= i_done_except_type[p];
          end
        end
      end
    end
  end

  assign o_valid        = r_valid;
  assign o_grp_id       = r_grp_id;
  assign o_done_grp_id  = r_done;
  assign o_except_valid = r_except_valid;
  assign o_except_type  = r_except_type;
  assign o_dead         = r_dead;
  assign o_pc           = r_pc;
  assign o_all_done     = r_valid & ((r_done & r_grp_id) == r_grp_id);

endmodule

// File: rob/rob_commit.sv
/*
 * Commit stage: decides on the oldest entry, selects the first live exception
 * and its pc, builds the dead mask and registers commit and credit outputs.
 */

`timescale 1ns/1ps

module rob_commit
  import rob_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,

  // oldest entry
  input  cmt_id_t i_out_ptr,
  input  logic    i_valid,
  input  logic    i_all_done,
  input  grp_id_t i_grp_id,
  input  grp_id_t i_except_valid,
  input  except_t i_except_type [DISP_SIZE],
  input  grp_id_t i_dead,
  input  vaddr_t  i_pc,

  output logic    o_commit_finish,
  output logic    o_flush,

  output logic    o_commit_valid,
  output cmt_id_t o_commit_cmt_id,
  output grp_id_t o_commit_grp_id,
  output grp_id_t o_commit_dead_id,
  output logic    o_commit_except_valid,
  output except_t o_commit_except_type,
  output vaddr_t  o_commit_epc,

  output logic    o_credit_return_valid,
  output credit_t o_credit_return_val
);

  logic    w_commit;
  grp_id_t w_live_exc;
  grp_id_t w_exc_oh;
  grp_id_t w_exc_oh_shl;
  grp_id_t w_upto_exc;
  grp_id_t w_dead_id;
  logic    w_except_valid;
  except_t w_except_type;
  vaddr_t  w_slot_pc [DISP_SIZE];
  vaddr_t  w_epc;

  assign w_commit = i_valid & i_all_done;

  // --------------------------------------------------------------------
  // exception slot and dead mask
  // --------------------------------------------------------------------
  assign w_live_exc = i_except_valid & ~i_dead & i_grp_id;  // dead slots can't raise
  assign w_exc_oh   = w_live_exc & (~w_live_exc + grp_id_t'(1));  // lowest set bit

  // bits 0..k set for excepting slot k; all ones when nothing excepts
  assign w_exc_oh_shl = {w_exc_oh[DISP_SIZE-2:0], 1'b0};
  assign w_upto_exc   = w_exc_oh_shl - grp_id_t'(1);

  assign w_dead_id      = (~w_upto_exc | i_dead) & i_grp_id;
  assign w_except_valid = |w_exc_oh;

  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot_pc
      assign w_slot_pc[d] = i_pc + vaddr_t'(d * INST_BYTES);
    end
  endgenerate

  oh_select #(
    .T     (except_t),
    .WORDS (DISP_SIZE)
  ) u_except_sel (
    .i_oh       (w_exc_oh),
    .i_data     (i_except_type),
    .o_selected (w_except_type)
  );

  oh_select #(
    .T     (vaddr_t),
    .WORDS (DISP_SIZE)
  ) u_epc_sel (
    .i_oh       (w_exc_oh),
    .i_data     (w_slot_pc),
    .o_selected (w_epc)
  );

  // --------------------------------------------------------------------
  // registered outputs
  // --------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_commit_valid        <= 1'b0;
      o_credit_return_valid <= 1'b0;
      o_credit_return_val   <= '0;
    end else begin
      o_commit_valid        <= w_commit;
      o_credit_return_valid <= w_commit;
      o_credit_return_val   <= w_commit ? credit_t'(1) : '0;  // one group per commit
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_commit) begin
      o_commit_cmt_id       <= i_out_ptr;
      o_commit_grp_id       <= i_grp_id;
      o_commit_dead_id      <= w_dead_id;
      o_commit_except_valid <= w_except_valid;
      o_commit_except_type  <= w_except_type;
      o_commit_epc          <= w_epc;
    end
  end

  assign o_commit_finish = w_commit;

  // high in the deciding cycle and the one after
  assign o_flush = (w_commit & w_except_valid) |
                   (o_commit_valid & o_commit_except_valid);

endmodule

// File: rob/rob_top.sv
/*
 * Reorder buffer top: pointers, the circular entry array and the commit stage.
 * The source must hold a credit for every dispatch, there is no back-pressure.
 */

`timescale 1ns/1ps

module rob_top
  import rob_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,

  // dispatch
  input  logic    i_disp_valid,
  input  grp_id_t i_disp_grp_id,
  input  vaddr_t  i_disp_pc,
  input  grp_id_t i_disp_except_valid,
  input  except_t i_disp_except_type [DISP_SIZE],
  output cmt_id_t o_new_cmt_id,

  // done reports
  input  logic    i_done_valid        [CMT_BUS_SIZE],
  input  cmt_id_t i_done_cmt_id       [CMT_BUS_SIZE],
  input  grp_id_t i_done_grp_id       [CMT_BUS_SIZE],
  input  logic    i_done_except_valid [CMT_BUS_SIZE],
  input  except_t i_done_except_type  [CMT_BUS_SIZE],

  // commit
  output logic    o_commit_valid,
  output cmt_id_t o_commit_cmt_id,
  output grp_id_t o_commit_grp_id,
  output grp_id_t o_commit_dead_id,
  output logic    o_commit_except_valid,
  output except_t o_commit_except_type,
  output vaddr_t  o_commit_epc,

  // credits back to dispatch
  output logic    o_credit_return_valid,
  output credit_t o_credit_return_val
);

  cmt_id_t                w_in_ptr;
  cmt_id_t                w_out_ptr;
  logic [CMT_ENTRY_W-1:0] w_in_idx;
  logic [CMT_ENTRY_W-1:0] w_out_idx;
  logic                   w_commit_finish;
  logic                   w_flush;

  logic [CMT_ENTRY_SIZE-1:0] w_valid;
  logic [CMT_ENTRY_SIZE-1:0] w_all_done;
  grp_id_t w_grp_id       [CMT_ENTRY_SIZE];
  grp_id_t w_except_valid [CMT_ENTRY_SIZE];
  except_t w_except_type  [CMT_ENTRY_SIZE][DISP_SIZE];
  grp_id_t w_dead         [CMT_ENTRY_SIZE];
  vaddr_t  w_pc           [CMT_ENTRY_SIZE];

  except_t w_out_except_type [DISP_SIZE];

  assign w_in_idx     = w_in_ptr[CMT_ENTRY_W-1:0];
  assign w_out_idx    = w_out_ptr[CMT_ENTRY_W-1:0];
  assign o_new_cmt_id = w_in_ptr;

  rob_ptr u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (i_disp_valid),
    .i_out_valid (w_commit_finish),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr)
  );

  // --------------------------------------------------------------------
  // entry array
  // --------------------------------------------------------------------
  generate
    for (genvar c = 0; c < CMT_ENTRY_SIZE; c++) begin : g_entry
      logic w_load;
      logic w_finish;

      assign w_load   = i_disp_valid & (w_in_idx == CMT_ENTRY_W'(c));
      assign w_finish = w_commit_finish & (w_out_idx == CMT_ENTRY_W'(c));

      rob_entry #(
        .ENTRY_IDX (c)
      ) u_entry (
        .i_clk               (i_clk),
        .i_reset_n           (i_reset_n),
        .i_load_valid        (w_load),
        .i_in_wrap           (w_in_ptr[CMT_ENTRY_W]),
        .i_disp_grp_id       (i_disp_grp_id),
        .i_disp_pc           (i_disp_pc),
        .i_disp_except_valid (i_disp_except_valid),
        .i_disp_except_type  (i_disp_except_type),
        .i_done_valid        (i_done_valid),
        .i_done_cmt_id       (i_done_cmt_id),
        .i_done_grp_id       (i_done_grp_id),
        .i_done_except_valid (i_done_except_valid),
        .i_done_except_type  (i_done_except_type),
        .i_kill              (w_flush),
        .i_commit_finish     (w_finish),
        .o_valid             (w_valid[c]),
        .o_grp_id            (w_grp_id[c]),
        .o_done_grp_id       (),
        .o_except_valid      (w_except_valid[c]),
        .o_except_type       (w_except_type[c]),
        .o_dead              (w_dead[c]),
        .o_pc                (w_pc[c]),
        .o_all_done          (w_all_done[c])
      );
    end
  endgenerate

  // oldest entry view
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_out_except_type[d] = w_except_type[w_out_idx][d];
    end
  end

  rob_commit u_commit (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_out_ptr             (w_out_ptr),
    .i_valid               (w_valid[w_out_idx]),
    .i_all_done            (w_all_done[w_out_idx]),
    .i_grp_id              (w_grp_id[w_out_idx]),
    .i_except_valid        (w_except_valid[w_out_idx]),
    .i_except_type         (w_out_except_type),
    .i_dead                (w_dead[w_out_idx]),
    .i_pc                  (w_pc[w_out_idx]),
    .o_commit_finish       (w_commit_finish),
    .o_flush               (w_flush),
    .o_commit_valid        (o_commit_valid),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_grp_id       (o_commit_grp_id),
    .o_commit_dead_id      (o_commit_dead_id),
    .o_commit_except_valid (o_commit_except_valid),
    .o_commit_except_type  (o_commit_except_type),
    .o_commit_epc          (o_commit_epc),
    .o_credit_return_valid (o_credit_return_valid),
    .o_credit_return_val   (o_credit_return_val)
  );

endmodule

// File: sim/tb_rob_model.svh
/*
 * Reference model for the reorder buffer testbench, included inside tb_rob.
 * Builds the commit a group should produce from what was dispatched and reported.
 */

`ifndef TB_ROB_MODEL_SVH
`define TB_ROB_MODEL_SVH

typedef struct packed {
  cmt_id_t id;
  grp_id_t grp;
  grp_id_t dead;
  logic    exc_valid;
  except_t exc_type;
  vaddr_t  epc;
} commit_rec_t;

// ids count up in dispatch order, wrap bit flips every CMT_ENTRY_SIZE groups
function automatic cmt_id_t id_of_seq(input int seq);
  return cmt_id_t'(seq % (2 * CMT_ENTRY_SIZE));
endfunction

// lowest valid slot that raised an exception, -1 when none
function automatic int first_exc_slot(input grp_id_t grp, input grp_id_t exc);
  int slot;
  slot = -1;
  for (int d = DISP_SIZE - 1; d >= 0; d--) begin
    if (grp[d] && exc[d]) begin
      slot = d;
    end
  end
  return slot;
endfunction

function automatic grp_id_t exp_dead_mask(input grp_id_t grp, input grp_id_t exc,
                                          input logic killed);
  grp_id_t dead;
  int      k;
  dead = '0;
  k    = first_exc_slot(grp, exc);
  if (killed) begin
    dead = grp;                  // flushed group, nothing survives
  end else if (k >= 0) begin
    for (int d = k + 1; d < DISP_SIZE; d++) begin
      dead[d] = grp[d];
    end
  end
  return dead;
endfunction

function automatic commit_rec_t exp_commit(input int seq, input grp_id_t grp,
                                           input grp_id_t exc,
                                           input except_t types [DISP_SIZE],
                                           input vaddr_t pc, input logic killed);
  commit_rec_t rec;
  int          k;
  k             = killed ? -1 : first_exc_slot(grp, exc);
  rec.id        = id_of_seq(seq);
  rec.grp       = grp;
  rec.dead      = exp_dead_mask(grp, exc, killed);
  rec.exc_valid = (k >= 0);
  rec.exc_type  = (k >= 0) ? types[k] : EXC_NONE;
  rec.epc       = (k >= 0) ? pc + vaddr_t'(k * INST_BYTES) : '0;  // slot pc
  return rec;
endfunction

`endif

// File: sim/tb_rob.sv
/*
 * Testbench for the reorder buffer. Dispatches groups, sends done reports
 * on both ports and checks each commit against the reference model.
 */

`timescale 1ns/1ps

module tb_rob
  import rob_pkg::*;
();

  `include "tb_rob_model.svh"

  localparam int MAX_GRP    = 128;
  localparam int WAIT_LIMIT = 200;  // cycles per wait loop

  logic    i_clk;
  logic    i_reset_n;
  logic    i_disp_valid;
  grp_id_t i_disp_grp_id;
  vaddr_t  i_disp_pc;
  grp_id_t i_disp_except_valid;
  except_t i_disp_except_type [DISP_SIZE];
  cmt_id_t o_new_cmt_id;
  logic    i_done_valid        [CMT_BUS_SIZE];
  cmt_id_t i_done_cmt_id       [CMT_BUS_SIZE];
  grp_id_t i_done_grp_id       [CMT_BUS_SIZE];
  logic    i_done_except_valid [CMT_BUS_SIZE];
  except_t i_done_except_type  [CMT_BUS_SIZE];
  logic    o_commit_valid;
  cmt_id_t o_commit_cmt_id;
  grp_id_t o_commit_grp_id;
  grp_id_t o_commit_dead_id;
  logic    o_commit_except_valid;
  except_t o_commit_except_type;
  vaddr_t  o_commit_epc;
  logic    o_credit_return_valid;
  credit_t o_credit_return_val;

  // per group model state, indexed by dispatch sequence number
  grp_id_t m_grp      [MAX_GRP];
  vaddr_t  m_pc       [MAX_GRP];
  grp_id_t m_exc      [MAX_GRP];
  grp_id_t m_late_exc [MAX_GRP];  // slots whose done report excepts
  grp_id_t m_done     [MAX_GRP];
  logic    m_killed   [MAX_GRP];
  except_t m_type     [MAX_GRP][DISP_SIZE];

  int exp_q  [$];  // expected commits, oldest first
  int pend_q [$];  // seq * DISP_SIZE + slot
  int seed;
  int errors;
  int err_mark;
  int n_tests;
  int n_groups;
  int n_commits;
  int credits;

  rob_top DUT (.*);

  always #5 i_clk = ~i_clk;

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic except_t pick_cause();
    except_t c;
    case (rand_below(5))
      0:       c = INST_ACC_FAULT;
      1:       c = ILLEGAL_INST;
      2:       c = LOAD_ACC_FAULT;
      3:       c = STORE_ACC_FAULT;
      default: c = ECALL;
    endcase
    return c;
  endfunction

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic end_run();
    $display("tests %0d, groups %0d, commits %0d, credits %0d, errors %0d",
             n_tests, n_groups, n_commits, credits, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("timeout: %s", what);
    errors++;
    end_run();
  endtask

  task automatic test_done(input string name);
    n_tests++;
    $display("test %s finished with %0d errors", name, errors - err_mark);
  endtask

  // every driver wait goes through here so no credit is missed
  task automatic tick();
    @(negedge i_clk);
    if (o_credit_return_valid) begin
      credits = credits + int'(o_credit_return_val);
    end
  endtask

  task automatic clear_disp();
    i_disp_valid        = 1'b0;
    i_disp_grp_id       = '0;
    i_disp_pc           = '0;
    i_disp_except_valid = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_disp_except_type[d] = EXC_NONE;
    end
  endtask

  task automatic clear_done();
    for (int p = 0; p < CMT_BUS_SIZE; p++) begin
      i_done_valid[p]        = 1'b0;
      i_done_cmt_id[p]       = '0;
      i_done_grp_id[p]       = '0;
      i_done_except_valid[p] = 1'b0;
      i_done_except_type[p]  = EXC_NONE;
    end
  endtask

  task automatic dispatch_group(input int n_slots, input grp_id_t early, output int seq);
    int waited;
    waited = 0;
    while (credits == 0) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) begin
        give_up("no credit came back for a pending dispatch");
      end
    end
    seq             = n_groups;
    n_groups++;
    m_grp[seq]      = grp_id_t'((1 << n_slots) - 1);
    m_pc[seq]       = vaddr_t'($random(seed)) & ~vaddr_t'(3);
    m_exc[seq]      = early & m_grp[seq];
    m_done[seq]     = m_exc[seq];   // early exceptions are done on entry
    m_late_exc[seq] = '0;
    m_killed[seq]   = 1'b0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      m_type[seq][d]        = m_exc[seq][d] ? pick_cause() : EXC_NONE;
      i_disp_except_type[d] = m_type[seq][d];
    end
    check_eq("new commit id", o_new_cmt_id, id_of_seq(seq));
    i_disp_valid        = 1'b1;
    i_disp_grp_id       = m_grp[seq];
    i_disp_pc           = m_pc[seq];
    i_disp_except_valid = m_exc[seq];
    exp_q.push_back(seq);
    credits--;
    tick();
    clear_disp();
  endtask

  task automatic add_pending(input int seq, input grp_id_t skip);
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (m_grp[seq][d] && !m_done[seq][d] && !skip[d]) begin
        pend_q.push_back(seq * DISP_SIZE + d);
      end
    end
  endtask

  task automatic shuffle_pending();
    int j;
    int t;
    for (int i = pend_q.size() - 1; i > 0; i--) begin
      j         = rand_below(i + 1);
      t         = pend_q[i];
      pend_q[i] = pend_q[j];
      pend_q[j] = t;
    end
  endtask

  task automatic drive_port(input int p, input int item);
    int seq;
    int slot;
    seq                    = item / DISP_SIZE;
    slot                   = item % DISP_SIZE;
    i_done_valid[p]        = 1'b1;
    i_done_cmt_id[p]       = id_of_seq(seq);
    i_done_grp_id[p]       = grp_id_t'(1 << slot);
    i_done_except_valid[p] = m_late_exc[seq][slot];
    i_done_except_type[p]  = EXC_NONE;
    if (m_late_exc[seq][slot]) begin
      m_type[seq][slot]     = pick_cause();
      m_exc[seq][slot]      = 1'b1;
      i_done_except_type[p] = m_type[seq][slot];
    end
    m_done[seq][slot] = 1'b1;
  endtask

  // one report per cycle, or two when dual and the coin says so
  task automatic issue_pending(input logic dual);
    while (pend_q.size() > 0) begin
      drive_port(0, pend_q.pop_front());
      if (dual && pend_q.size() > 0 && rand_below(2) == 1) begin
        drive_port(1, pend_q.pop_front());
      end
      tick();
      clear_done();
    end
  endtask

  // two spare cycles keep the next dispatch out of any flush window
  task automatic drain(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) begin
        give_up({"groups never committed in test ", name});
      end
    end
    tick();
    tick();
  endtask

  // --------------------------------------------------------------------
  // commit checker
  // --------------------------------------------------------------------
  always @(negedge i_clk) begin : compare_commits
    commit_rec_t want;
    int          seq;
    if (i_reset_n) begin
      check_eq("credit pulse", o_credit_return_valid, o_commit_valid);
      if (o_commit_valid) begin
        check_eq("groups outstanding at commit", exp_q.size() > 0, 1);
        if (exp_q.size() > 0) begin
          seq  = exp_q.pop_front();
          want = exp_commit(seq, m_grp[seq], m_exc[seq], m_type[seq], m_pc[seq],
                            m_killed[seq]);
          check_eq("commit id", o_commit_cmt_id, want.id);
          check_eq("commit group", o_commit_grp_id, want.grp);
          check_eq("dead mask", o_commit_dead_id, want.dead);
          check_eq("exception valid", o_commit_except_valid, want.exc_valid);
          if (want.exc_valid) begin
            check_eq("exception type", o_commit_except_type, want.exc_type);
            check_eq("epc", o_commit_epc, want.epc);
          end
          if (!m_killed[seq]) begin
            check_eq("slots reported", m_done[seq], m_grp[seq]);
          end
          check_eq("credit value", o_credit_return_val, 1);
          n_commits++;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------
  task automatic fill_from_reset();
    int seq;
    int base;
    err_mark = errors;
    for (int g = 0; g < CMT_ENTRY_SIZE; g++) begin
      dispatch_group(1 + rand_below(DISP_SIZE), '0, seq);
      add_pending(seq, '0);
    end
    check_eq("credits left when full", credits, 0);
    check_eq("next id when full", o_new_cmt_id, id_of_seq(n_groups));
    base = n_commits;
    repeat (4) tick();
    check_eq("commits before any report", n_commits - base, 0);
    shuffle_pending();
    issue_pending(1'b1);
    drain("fill_from_reset");
    test_done("fill_from_reset");
  endtask

  task automatic in_order_groups();
    int seq;
    err_mark = errors;
    for (int g = 0; g < 12; g++) begin
      dispatch_group(1 + rand_below(DISP_SIZE), '0, seq);
      add_pending(seq, '0);
      issue_pending(1'b0);
    end
    drain("in_order_groups");
    test_done("in_order_groups");
  endtask

  task automatic shuffled_reports();
    int seq;
    err_mark = errors;
    for (int g = 0; g < 6; g++) begin
      dispatch_group(1 + rand_below(DISP_SIZE), '0, seq);
      add_pending(seq, '0);
    end
    shuffle_pending();
    issue_pending(1'b1);
    drain("shuffled_reports");
    test_done("shuffled_reports");
  endtask

  task automatic early_exceptions();
    int      seq;
    int      n;
    grp_id_t mask;
    err_mark = errors;
    for (int g = 0; g < 4; g++) begin
      n    = 1 + rand_below(DISP_SIZE);
      mask = grp_id_t'(1 << rand_below(n)) | grp_id_t'($random(seed));
      dispatch_group(n, mask, seq);
      add_pending(seq, '0);
      issue_pending(1'b1);
      drain("early_exceptions");
    end
    test_done("early_exceptions");
  endtask

  task automatic late_exception_flush();
    int a;
    int b;
    int c;
    int k;
    int base;
    err_mark = errors;
    for (int g = 0; g < 3; g++) begin
      dispatch_group(DISP_SIZE, '0, a);
      dispatch_group(1 + rand_below(DISP_SIZE), '0, b);
      dispatch_group(1 + rand_below(DISP_SIZE), '0, c);
      m_late_exc[b] = grp_id_t'(1 << rand_below(DISP_SIZE)) & m_grp[b];
      m_late_exc[c] = m_grp[c];
      k = rand_below(DISP_SIZE);
      add_pending(b, '0);
      add_pending(c, '0);
      add_pending(a, grp_id_t'(1 << k));   // hold back the excepting slot
      shuffle_pending();
      issue_pending(1'b1);
      base = n_commits;
      repeat (3) tick();
      check_eq("commits while oldest waits", n_commits - base, 0);
      m_killed[b]   = 1'b1;
      m_killed[c]   = 1'b1;
      m_late_exc[a] = grp_id_t'(1 << k);
      add_pending(a, '0);
      issue_pending(1'b0);
      drain("late_exception_flush");
    end
    test_done("late_exception_flush");
  endtask

  initial begin
    seed      = 32'hb54f_034b;
    errors    = 0;
    err_mark  = 0;
    n_tests   = 0;
    n_groups  = 0;
    n_commits = 0;
    credits   = CMT_ENTRY_SIZE;
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    clear_disp();
    clear_done();
    tick();
    tick();
    i_reset_n = 1'b1;

    fill_from_reset();
    in_order_groups();
    shuffled_reports();
    early_exceptions();
    late_exception_flush();

    check_eq("credits held at end", credits, CMT_ENTRY_SIZE);
    end_run();
  end

endmodule

// File: vlog.f
+incdir+sim
common/rob_pkg.sv
rtl/oh_select.sv
rob/rob_ptr.sv
rob/rob_entry.sv
rob/rob_commit.sv
rob/rob_top.sv
sim/tb_rob.sv

// File: Bender.yml
package:
  name: rob

sources:
  # reorder buffer RTL
  - files:
      - common/rob_pkg.sv
      - rtl/oh_select.sv
      - rob/rob_ptr.sv
      - rob/rob_entry.sv
      - rob/rob_commit.sv
      - rob/rob_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rob.sv
